// ==== project.f ====
+incdir+hw
hw/clic_pkg.sv
hw/csr_bus_if.sv
hw/csr_reg.sv
hw/clic_arbiter.sv
hw/epc_stack.sv
hw/n_clic.sv
hw/clic_top.sv
verification/clic_sva.sv
verification/clic_checker.sv
verification/clic_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the clic testbench with Verilator

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal -j 0 \
  --top-module clic_tb -f project.f -o clic_sim
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

./obj_dir/clic_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "TESTS FAILED" sim.log; then
  exit 1
fi
if ! grep -q "TESTS PASSED" sim.log; then
  echo "no result line in sim.log"
  exit 1
fi
exit 0

// ==== verification/clic_tb.sv ====
// clic testbench top
`timescale 1ns/100ps
`include "clic_cfg.svh"

module clic_tb;
  import clic_pkg::*;

  localparam int nvec = `CLIC_VEC_SIZE;
  localparam int levels = `CLIC_PRIO_LEVELS;
  localparam int n_ops = 300;
  localparam int n_arb = 20;
  localparam int n_take = 10;
  localparam int n_conf = 8;
  // cycles per test, fixed sequences rounded up
  localparam int total_cycles = n_ops + n_arb * (2 * nvec + 12) + n_take * 10
                                + n_conf * 12 + 2 * nvec + 120;

  logic      clk;
  logic      rst;
  logic      csr_enable;
  csr_addr_t csr_addr;
  csr_op_t   csr_op;
  zimm_t     rs1_zimm;
  word       rs1_data;
  pc_t       pc_in;
  logic      mret;
  word       csr_rdata;
  pc_t       pc_out;
  logic      int_take;
  int        errors;

  word rng;
  int  err_mark;
  int  test_count;
  int  failed_tests;

  clic_top dut (.*);

  clic_checker u_chk (
    .clk, .rst, .csr_enable, .csr_addr, .csr_op, .rs1_zimm, .rs1_data,
    .pc_in, .mret, .csr_rdata, .pc_out, .int_take,
    .err_count (errors)
  );

  initial begin
    clk = 1'b0;
    forever begin
      #20 clk = 1'b1;
      #20 clk = 1'b0;
    end
  end

  // xorshift32
  function automatic word next_rand();
    rng = rng ^ (rng << 13);
    rng = rng ^ (rng >> 17);
    rng = rng ^ (rng << 5);
    return rng;
  endfunction

  function automatic csr_addr_t vec_addr(input int k);
    return csr_addr_t'(int'(`CLIC_VEC_CSR_BASE) + k);
  endfunction

  function automatic csr_addr_t entry_addr(input int k);
    return csr_addr_t'(int'(`CLIC_ENTRY_CSR_BASE) + k);
  endfunction

  // mostly mapped, 0x800 page is never decoded
  function automatic csr_addr_t rand_addr();
    word r;
    int  k;
    r = next_rand();
    k = int'((r >> 8) % nvec);
    case (r[2:0])
      3'd0, 3'd1:       return vec_addr(k);
      3'd2, 3'd3, 3'd4: return entry_addr(k);
      3'd5:             return `CLIC_MINTTHRESH_ADDR;
      3'd6:             return `CLIC_STACK_DEPTH_ADDR;
      default:          return csr_addr_t'(12'h800 + r[15:8]);
    endcase
  endfunction

  function automatic csr_op_t rand_op();
    case (next_rand() % 6)
      0:       return csr_rw;
      1:       return csr_rs;
      2:       return csr_rc;
      3:       return csr_rwi;
      4:       return csr_rsi;
      default: return csr_rci;
    endcase
  endfunction

  // one cycle of stimulus just after the rising edge, unused source gets noise
  task automatic drive(input logic en, input csr_addr_t addr, input csr_op_t op,
                       input word val, input logic ret);
    word r;
    @(posedge clk);
    #2;
    r          = next_rand();
    csr_enable = en;
    csr_addr   = addr;
    csr_op     = op;
    rs1_zimm   = (op inside {csr_rwi, csr_rsi, csr_rci}) ? val[4:0] : r[4:0];
    rs1_data   = (op inside {csr_rwi, csr_rsi, csr_rci}) ? r : val;
    pc_in      = pc_t'(r >> 8);
    mret       = ret;
  endtask

  task automatic peek(input csr_addr_t addr);
    drive(1'b0, addr, csr_none, '0, 1'b0);
  endtask

  task automatic pulse_reset();
    @(posedge clk);
    #2;
    rst        = 1'b1;
    csr_enable = 1'b0;
    mret       = 1'b0;
    repeat (2) @(posedge clk);
    #2;
    rst = 1'b0;
  endtask

  // entry value with pended and enabled set
  function automatic word armed(input word prio);
    return (prio << 2) | 32'd3;
  endfunction

  task automatic end_test(input string name);
    int n;
    peek(rand_addr());
    @(negedge clk);
    #1;
    n        = errors - err_mark;
    err_mark = errors;
    test_count++;
    if (n != 0)
      failed_tests++;
    $display("test %0d %s: %0d errors", test_count, name, n);
  endtask

  task automatic csr_op_sweep();
    repeat (n_ops) drive(1'b1, rand_addr(), rand_op(), next_rand(), 1'b0);
    end_test("csr operations");
  endtask

  task automatic arbitration_rounds();
    word r;
    for (int n = 0; n < n_arb; n++) begin
      pulse_reset();
      // top threshold holds off every take while the table fills
      drive(1'b1, `CLIC_MINTTHRESH_ADDR, csr_rwi, word'(levels - 1), 1'b0);
      for (int k = 0; k < nvec; k++) begin
        r = next_rand();
        drive(1'b1, vec_addr(k), csr_rw, next_rand(), 1'b0);
        // upper half of the levels so ties are common
        drive(1'b1, entry_addr(k), csr_rwi,
              ((levels / 2 + r % (levels / 2)) << 2) | word'({r[2] | r[3], r[4] | r[5]}),
              1'b0);
      end
      drive(1'b1, `CLIC_MINTTHRESH_ADDR, csr_rwi, next_rand() % 4, 1'b0);
      repeat (6) peek(rand_addr());
    end
    end_test("arbitration");
  endtask

  task automatic take_effects();
    int  k;
    word p;
    for (int n = 0; n < n_take; n++) begin
      pulse_reset();
      k = int'(next_rand() % nvec);
      p = 1 + next_rand() % (levels - 1);
      drive(1'b1, vec_addr(k), csr_rw, next_rand(), 1'b0);
      drive(1'b1, entry_addr(k), csr_rwi, armed(p), 1'b0);
      // take cycle, then threshold, entry and depth read back
      peek(rand_addr());
      peek(`CLIC_MINTTHRESH_ADDR);
      peek(entry_addr(k));
      peek(`CLIC_STACK_DEPTH_ADDR);
    end
    end_test("take side effects");
  endtask

  task automatic nesting_and_return();
    pulse_reset();
    drive(1'b1, vec_addr(0), csr_rw, 32'h10, 1'b0);
    drive(1'b1, vec_addr(1), csr_rw, 32'h20, 1'b0);
    drive(1'b1, vec_addr(2), csr_rw, 32'h30, 1'b0);
    drive(1'b1, entry_addr(0), csr_rwi, armed(2), 1'b0);
    peek(`CLIC_MINTTHRESH_ADDR);
    // higher priority preempts the running handler
    drive(1'b1, entry_addr(1), csr_rwi, armed(5), 1'b0);
    peek(`CLIC_MINTTHRESH_ADDR);
    // held below the raised threshold until the return
    drive(1'b1, entry_addr(2), csr_rwi, armed(3), 1'b0);
    repeat (2) peek(`CLIC_STACK_DEPTH_ADDR);
    // extra returns land on an empty stack
    repeat (6) begin
      drive(1'b0, `CLIC_MINTTHRESH_ADDR, csr_none, '0, 1'b1);
      peek(`CLIC_STACK_DEPTH_ADDR);
    end
    end_test("nesting and return");
  endtask

  task automatic conflict_cases();
    int  k;
    word p;
    for (int n = 0; n < n_conf; n++) begin
      pulse_reset();
      k = int'(next_rand() % nvec);
      p = 2 + next_rand() % (levels - 2);
      drive(1'b1, entry_addr(k), csr_rwi, armed(p), 1'b0);
      // software threshold write in the take cycle
      drive(1'b1, `CLIC_MINTTHRESH_ADDR, csr_rwi, 32'd1, 1'b0);
      drive(1'b0, `CLIC_MINTTHRESH_ADDR, csr_none, '0, 1'b1);
      drive(1'b1, entry_addr(k), csr_rsi, 32'd1, 1'b0);
      // software pend in the take cycle
      drive(1'b1, entry_addr(k), csr_rsi, 32'd1, 1'b0);
      peek(entry_addr(k));
      peek(`CLIC_MINTTHRESH_ADDR);
    end
    end_test("conflict rules");
  endtask

  task automatic mid_run_reset();
    word r;
    repeat (30) begin
      r = next_rand();
      drive(1'b1, rand_addr(), rand_op(), next_rand(), r[1:0] == 2'b00);
    end
    pulse_reset();
    for (int k = 0; k < nvec; k++) begin
      peek(vec_addr(k));
      peek(entry_addr(k));
    end
    peek(`CLIC_MINTTHRESH_ADDR);
    peek(`CLIC_STACK_DEPTH_ADDR);
    peek(csr_addr_t'(12'h800));
    end_test("mid-run reset");
  endtask

  initial begin
    rng          = 32'd34;
    err_mark     = 0;
    test_count   = 0;
    failed_tests = 0;
    rst          = 1'b1;
    csr_enable   = 1'b0;
    csr_addr     = '0;
    csr_op       = csr_none;
    rs1_zimm     = '0;
    rs1_data     = '0;
    pc_in        = '0;
    mret         = 1'b0;
    repeat (2) @(posedge clk);
    #2;
    rst = 1'b0;
    csr_op_sweep();
    arbitration_rounds();
    take_effects();
    nesting_and_return();
    conflict_cases();
    mid_run_reset();
    $display("summary: %0d tests, %0d failed, %0d errors", test_count, failed_tests, errors);
    if (errors == 0 && failed_tests == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

  // watchdog, sized from the test lengths plus a margin
  initial begin
    repeat (total_cycles + 200) @(posedge clk);
    $display("watchdog: tests did not finish within %0d cycles", total_cycles + 200);
    $display("TESTS FAILED");
    $finish;
  end

endmodule

// ==== verification/clic_checker.sv ====
// clic reference model and comparator
`timescale 1ns/100ps
`include "clic_cfg.svh"

module clic_checker (
  input  logic                clk,
  input  logic                rst,
  input  logic                csr_enable,
  input  clic_pkg::csr_addr_t csr_addr,
  input  clic_pkg::csr_op_t   csr_op,
  input  clic_pkg::zimm_t     rs1_zimm,
  input  clic_pkg::word       rs1_data,
  input  clic_pkg::pc_t       pc_in,
  input  logic                mret,
  input  clic_pkg::word       csr_rdata,
  input  clic_pkg::pc_t       pc_out,
  input  logic                int_take,
  output int                  err_count
);
  import clic_pkg::*;

  localparam int nvec = `CLIC_VEC_SIZE;
  localparam int levels = `CLIC_PRIO_LEVELS;
  localparam int prio_w = $clog2(`CLIC_PRIO_LEVELS);
  // register widths as software sees them
  localparam word vec_mask = (32'd1 << (`CLIC_IMEM_ADDR_WIDTH - 2)) - 32'd1;
  localparam word ent_mask = (32'd1 << (prio_w + 2)) - 32'd1;
  localparam word thr_mask = (32'd1 << prio_w) - 32'd1;

  // model state
  word m_vec [nvec];
  word m_ent [nvec];
  word m_thr;
  word stk_pc [levels];
  word stk_th [levels];
  int  m_depth;
  bit  primed;
  int  errs;

  assign err_count = errs;

  initial begin
    errs   = 0;
    primed = 1'b0;
  end

  task automatic compare(input string name, input word got, input word exp);
    if (got !== exp) begin
      errs++;
      $display("[FAIL] t=%0t %s expected=%h got=%h", $time, name, exp, got);
    end
  endtask

  task automatic reset_model();
    for (int k = 0; k < nvec; k++) begin
      m_vec[k] = '0;
      m_ent[k] = '0;
    end
    m_thr   = '0;
    m_depth = 0;
  endtask

  // old value at an address or zero when unmapped
  function automatic word read_model(input csr_addr_t a);
    word v;
    v = '0;
    for (int k = 0; k < nvec; k++) begin
      if (int'(a) == int'(`CLIC_VEC_CSR_BASE) + k)
        v = m_vec[k];
      if (int'(a) == int'(`CLIC_ENTRY_CSR_BASE) + k)
        v = m_ent[k];
    end
    if (a == `CLIC_MINTTHRESH_ADDR)
      v = m_thr;
    if (a == `CLIC_STACK_DEPTH_ADDR)
      v = word'(m_depth);
    return v;
  endfunction

  // depth and unmapped addresses take no writes
  task automatic write_model(input csr_addr_t a, input word v);
    for (int k = 0; k < nvec; k++) begin
      if (int'(a) == int'(`CLIC_VEC_CSR_BASE) + k)
        m_vec[k] = v & vec_mask;
      if (int'(a) == int'(`CLIC_ENTRY_CSR_BASE) + k)
        m_ent[k] = v & ent_mask;
    end
    if (a == `CLIC_MINTTHRESH_ADDR)
      m_thr = v & thr_mask;
  endtask

  // riscv csrrw, csrrs and csrrc semantics
  function automatic word sw_result(input csr_op_t op, input word cur, input word src);
    case (op)
      csr_rw, csr_rwi: return src;
      csr_rs, csr_rsi: return cur | src;
      csr_rc, csr_rci: return cur & ~src;
      default:         return cur;
    endcase
  endfunction

  function automatic bit active(input int k);
    return m_ent[k][0] && m_ent[k][1];
  endfunction

  // outputs settle well before the falling edge
  always @(negedge clk) begin : model_step
    int  best;
    int  win;
    bit  ret;
    bit  take;
    word exp_pc;
    word src;
    word win_ent;
    word old_thr;
    ret  = 1'b0;
    take = 1'b0;
    win  = -1;
    best = 0;
    if (primed) begin
      ret  = mret && (m_depth > 0);
      // highest priority first, then the lowest index holding it
      best = int'(m_thr);
      for (int k = 0; k < nvec; k++) begin
        if (active(k) && int'(m_ent[k] >> 2) > best)
          best = int'(m_ent[k] >> 2);
      end
      for (int k = 0; k < nvec; k++) begin
        if (win < 0 && active(k) && best > int'(m_thr) && int'(m_ent[k] >> 2) == best)
          win = k;
      end
      take = (win >= 0) && (m_depth < levels) && !ret;
      if (ret)
        exp_pc = stk_pc[m_depth - 1];
      else if (take)
        exp_pc = m_vec[win] << 2;
      else
        exp_pc = word'(pc_in);
      compare("int_take", word'(int_take), word'(take));
      compare("pc_out", word'(pc_out), exp_pc);
      compare("csr_rdata", csr_rdata, read_model(csr_addr));
    end
    if (rst) begin
      reset_model();
      primed = 1'b1;
    end else if (primed) begin
      // state as it was before any software write this cycle
      win_ent = take ? m_ent[win] : '0;
      old_thr = m_thr;
      if (csr_enable && csr_op != csr_none) begin
        src = (csr_op inside {csr_rwi, csr_rsi, csr_rci}) ? word'(rs1_zimm) : rs1_data;
        write_model(csr_addr, sw_result(csr_op, read_model(csr_addr), src));
      end
      // hardware updates land over any software write
      if (take) begin
        stk_pc[m_depth] = word'(pc_in);
        stk_th[m_depth] = old_thr;
        m_depth++;
        m_thr = word'(best);
        m_ent[win] = win_ent & ~32'd1;
      end else if (ret) begin
        m_thr = stk_th[m_depth - 1];
        m_depth--;
      end
    end
  end

endmodule

// ==== verification/clic_sva.sv ====
// clic bound assertions
`timescale 1ns/100ps
`include "clic_cfg.svh"

module clic_sva (
  input logic             clk,
  input logic             rst,
  input logic             int_take,
  input clic_pkg::pc_t    pc_out,
  input clic_pkg::depth_t depth
);
  import clic_pkg::*;

  // handler addresses are whole words
  a_take_aligned : assert property (@(posedge clk) disable iff (rst)
    int_take |-> (pc_out[1:0] == 2'b00))
    else $error("pc_out not word aligned on a take");

  // nesting never goes past one frame per priority level
  a_depth_bound : assert property (@(posedge clk) disable iff (rst)
    int'(depth) <= `CLIC_PRIO_LEVELS)
    else $error("stack depth above the level count");

  // cleared tables cannot raise a request
  a_quiet_after_reset : assert property (@(posedge clk)
    rst |=> !int_take)
    else $error("int_take high in the cycle after reset");

endmodule

bind n_clic clic_sva u_sva (
  .clk      (clk),
  .rst      (rst),
  .int_take (int_take),
  .pc_out   (pc_out),
  .depth    (depth)
);

// ==== hw/clic_top.sv ====
// clic top level
`timescale 1ns/100ps

module clic_top (
  input  logic                clk,
  input  logic                rst,
  input  logic                csr_enable,
  input  clic_pkg::csr_addr_t csr_addr,
  input  clic_pkg::csr_op_t   csr_op,
  input  clic_pkg::zimm_t     rs1_zimm,
  input  clic_pkg::word       rs1_data,
  input  clic_pkg::pc_t       pc_in,
  input  logic                mret,
  output clic_pkg::word       csr_rdata,
  output clic_pkg::pc_t       pc_out,
  output logic                int_take
);

  // core-side csr access
  csr_bus_if bus ();

  // requester side of the bus
  assign bus.enable = csr_enable;
  assign bus.addr   = csr_addr;
  assign bus.op     = csr_op;
  assign bus.zimm   = rs1_zimm;
  assign bus.wdata  = rs1_data;
  assign csr_rdata  = bus.rdata;

  n_clic u_clic (
    .clk,
    .rst,
    .bus      (bus.slave),
    .pc_in,
    .mret,
    .pc_out,
    .int_take
  );

endmodule

// ==== hw/n_clic.sv ====
// core-local interrupt controller
`timescale 1ns/100ps
`include "clic_cfg.svh"

module n_clic (
  input  logic          clk,
  input  logic          rst,
  csr_bus_if.slave      bus,
  input  clic_pkg::pc_t pc_in,
  input  logic          mret,
  output clic_pkg::pc_t pc_out,
  output logic          int_take
);
  import clic_pkg::*;

  // register bank contents
  vec_addr_t  vec_data   [`CLIC_VEC_SIZE];
  entry_t     entry_data [`CLIC_VEC_SIZE];
  prio_t      thresh;

  // pended bit clear on take
  logic       clr_pend   [`CLIC_VEC_SIZE];
  entry_t     clr_data   [`CLIC_VEC_SIZE];

  // threshold hardware write
  logic       thresh_we;
  prio_t      thresh_hw;

  // arbiter result
  logic       found;
  vec_idx_t   win_idx;
  prio_t      win_prio;
  vec_addr_t  win_vec;

  // stack side
  epc_frame_t push_frame;
  epc_frame_t top_frame;
  depth_t     depth;
  logic       full;
  logic       empty;
  logic       ret;

  word        rd_mux;

  // vector and entry tables
  for (genvar k = 0; k < `CLIC_VEC_SIZE; k++) begin : gen_vec
    // handler address, software only
    csr_reg #(
      .width   ($bits(vec_addr_t)),
      .address (csr_addr_t'(`CLIC_VEC_CSR_BASE + k))
    ) u_vec (
      .clk,
      .rst,
      .bus,
      .hw_we   (1'b0),
      .hw_data ('0),
      .data    (vec_data[k])
    );

    // pended clears only for the winning vector
    assign clr_pend[k] = int_take && (win_idx == vec_idx_t'(k));
    assign clr_data[k] = '{prio: entry_data[k].prio, enabled: entry_data[k].enabled,
                           pended: 1'b0};

    csr_reg #(
      .width   ($bits(entry_t)),
      .address (csr_addr_t'(`CLIC_ENTRY_CSR_BASE + k))
    ) u_entry (
      .clk,
      .rst,
      .bus,
      .hw_we   (clr_pend[k]),
      .hw_data (clr_data[k]),
      .data    (entry_data[k])
    );
  end

  // machine interrupt threshold
  csr_reg #(
    .width   ($bits(prio_t)),
    .address (`CLIC_MINTTHRESH_ADDR)
  ) u_thresh (
    .clk,
    .rst,
    .bus,
    .hw_we   (thresh_we),
    .hw_data (thresh_hw),
    .data    (thresh)
  );

  clic_arbiter u_arb (
    .entries   (entry_data),
    .vectors   (vec_data),
    .threshold (thresh),
    .found,
    .win_idx,
    .win_prio,
    .win_vec
  );

  // frame holds the interrupted pc and the threshold it ran under
  assign push_frame = '{pc: pc_in, thresh: thresh};

  epc_stack u_stack (
    .clk,
    .rst,
    .push     (int_take),
    .pop      (ret),
    .data_in  (push_frame),
    .data_out (top_frame),
    .depth,
    .full,
    .empty
  );

  // mret on an empty stack does nothing
  assign ret = mret && !empty;
  // return beats take, full stack blocks nesting
  assign int_take = found && !full && !ret;

  // threshold raised on take, restored on return
  assign thresh_we = int_take || ret;
  assign thresh_hw = ret ? top_frame.thresh : win_prio;

  // program counter redirect
  always_comb begin
    if (ret) begin
      pc_out = top_frame.pc;
    end else if (int_take) begin
      // word address to byte address
      pc_out = {win_vec, 2'b00};
    end else begin
      pc_out = pc_in;
    end
  end

  // one-hot read mux, addresses never overlap
  always_comb begin
    rd_mux = '0;
    for (int k = 0; k < `CLIC_VEC_SIZE; k++) begin
      rd_mux |= (bus.addr == csr_addr_t'(`CLIC_VEC_CSR_BASE + k)) ?
                word'(vec_data[k]) : '0;
      rd_mux |= (bus.addr == csr_addr_t'(`CLIC_ENTRY_CSR_BASE + k)) ?
                word'(entry_data[k]) : '0;
    end
    rd_mux |= (bus.addr == `CLIC_MINTTHRESH_ADDR) ? word'(thresh) : '0;
    // nesting depth is read-only
    rd_mux |= (bus.addr == `CLIC_STACK_DEPTH_ADDR) ? word'(depth) : '0;
  end

  assign bus.rdata = rd_mux;

endmodule

// ==== hw/epc_stack.sv ====
// epc and threshold stack
`timescale 1ns/100ps
`include "clic_cfg.svh"

module epc_stack (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   push,
  input  logic                   pop,
  input  clic_pkg::epc_frame_t   data_in,
  output clic_pkg::epc_frame_t   data_out,
  output clic_pkg::depth_t       depth,
  output logic                   full,
  output logic                   empty
);
  import clic_pkg::*;

  typedef logic [$clog2(`CLIC_PRIO_LEVELS)-1:0] slot_t;

  // frame storage
  epc_frame_t mem [`CLIC_PRIO_LEVELS];
  // number of frames held, next free slot
  depth_t     ptr;

  assign full  = (ptr == depth_t'(`CLIC_PRIO_LEVELS));
  assign empty = (ptr == '0);
  assign depth = ptr;

  // pointer
  // push and pop never arrive together
  always_ff @(posedge clk) begin
    if (rst) begin
      ptr <= '0;
    end else if (push && !full) begin
      ptr <= ptr + 1'b1;
    end else if (pop && !empty) begin
      ptr <= ptr - 1'b1;
    end
  end

  // frames written at the free slot
  always_ff @(posedge clk) begin
    if (push && !full) begin
      mem[slot_t'(ptr)] <= data_in;
    end
  end

  // top of stack
  // meaningless while empty
  assign data_out = mem[slot_t'(ptr - 1'b1)];

endmodule

// ==== hw/clic_arbiter.sv ====
// interrupt priority arbiter
`timescale 1ns/100ps
`include "clic_cfg.svh"

module clic_arbiter (
  input  clic_pkg::entry_t    entries [`CLIC_VEC_SIZE],
  input  clic_pkg::vec_addr_t vectors [`CLIC_VEC_SIZE],
  input  clic_pkg::prio_t     threshold,
  output logic                found,
  output clic_pkg::vec_idx_t  win_idx,
  output clic_pkg::prio_t     win_prio,
  output clic_pkg::vec_addr_t win_vec
);
  import clic_pkg::*;

  // candidate state carried along the chain
  logic      best_found;
  vec_idx_t  best_idx;
  prio_t     best_prio;
  vec_addr_t best_vec;

  always_comb begin
    // chain is seeded with the threshold
    // so only priorities above it can win
    best_found = 1'b0;
    best_idx   = '0;
    best_prio  = threshold;
    best_vec   = '0;
    for (int i = 0; i < `CLIC_VEC_SIZE; i++) begin
      // strictly greater keeps the lowest index on a tie
      if (entries[i].pended && entries[i].enabled &&
          (entries[i].prio > best_prio)) begin
        best_found = 1'b1;
        best_idx   = vec_idx_t'(i);
        best_prio  = entries[i].prio;
        best_vec   = vectors[i];
      end
    end
  end

  assign found    = best_found;
  assign win_idx  = best_idx;
  // equals the threshold when nothing is found
  assign win_prio = best_prio;
  assign win_vec  = best_vec;

endmodule

// ==== hw/csr_reg.sv ====
// addressable csr
`timescale 1ns/100ps

module csr_reg #(
  parameter int width = 32,
  parameter clic_pkg::csr_addr_t address = '0,
  parameter logic [width-1:0] reset_val = '0
) (
  input  logic             clk,
  input  logic             rst,
  csr_bus_if.slave         bus,
  input  logic             hw_we,
  input  logic [width-1:0] hw_data,
  output logic [width-1:0] data
);
  import clic_pkg::*;

  logic hit;
  word  src;
  word  cur;
  word  nxt;

  // only this register's address is claimed
  assign hit = bus.enable && (bus.addr == address);
  assign cur = word'(data);

  // operand source
  always_comb begin
    case (bus.op)
      csr_rwi, csr_rsi, csr_rci: src = word'(bus.zimm);
      default:                   src = bus.wdata;
    endcase
  end

  // software result on the full word
  always_comb begin
    case (bus.op)
      csr_rw, csr_rwi: nxt = src;
      csr_rs, csr_rsi: nxt = cur | src;
      csr_rc, csr_rci: nxt = cur & ~src;
      default:         nxt = cur;
    endcase
  end

  // hardware update wins over software in the same cycle
  always_ff @(posedge clk) begin
    if (rst) begin
      data <= reset_val;
    end else if (hw_we) begin
      data <= hw_data;
    end else if (hit) begin
      // upper bits beyond the register width are dropped
      data <= nxt[width-1:0];
    end
  end

endmodule

// ==== hw/csr_bus_if.sv ====
// csr access bus
`timescale 1ns/100ps

interface csr_bus_if;
  import clic_pkg::*;

  // request, valid whenever enable is high
  logic      enable;
  csr_addr_t addr;
  csr_op_t   op;
  zimm_t     zimm;
  word       wdata;
  // combinational read of the old value
  word       rdata;

  // requester side
  modport master (
    output enable, addr, op, zimm, wdata,
    input  rdata
  );

  // register side
  modport slave (
    input  enable, addr, op, zimm, wdata,
    output rdata
  );

endinterface

// ==== hw/clic_pkg.sv ====
// clic shared types
`include "clic_cfg.svh"

package clic_pkg;

  // csr address space is 12 bits wide
  typedef logic [11:0] csr_addr_t;
  typedef logic [31:0] word;

  // immediate field of the csr*i forms
  typedef logic [4:0] zimm_t;

  // follows funct3 of the riscv csr instructions
  typedef enum logic [2:0] {
    csr_none = 3'b000,
    csr_rw   = 3'b001,
    csr_rs   = 3'b010,
    csr_rc   = 3'b011,
    csr_rwi  = 3'b101,
    csr_rsi  = 3'b110,
    csr_rci  = 3'b111
  } csr_op_t;

  typedef logic [$clog2(`CLIC_PRIO_LEVELS)-1:0] prio_t;
  typedef logic [`CLIC_IMEM_ADDR_WIDTH-1:0] pc_t;
  // handler address in words
  typedef logic [`CLIC_IMEM_ADDR_WIDTH-3:0] vec_addr_t;
  typedef logic [$clog2(`CLIC_VEC_SIZE)-1:0] vec_idx_t;
  // counts 0 up to and including a full stack
  typedef logic [$clog2(`CLIC_PRIO_LEVELS+1)-1:0] depth_t;

  // small enough to be written whole by a 5-bit immediate
  typedef struct packed {
    prio_t prio;
    logic  enabled;
    logic  pended;
  } entry_t;

  // one nesting level
  typedef struct packed {
    pc_t   pc;
    prio_t thresh;
  } epc_frame_t;

endpackage

// ==== hw/clic_cfg.svh ====
// clic build configuration
`ifndef CLIC_CFG_SVH
`define CLIC_CFG_SVH

// number of interrupt vectors
// entry csrs sit in a 32-slot window, so no more than 32
`define CLIC_VEC_SIZE 8

// priority levels
// also bounds the nesting depth of the epc stack
`define CLIC_PRIO_LEVELS 8

// byte address width of instruction memory
`define CLIC_IMEM_ADDR_WIDTH 12

// vector table, one csr per vector
`define CLIC_VEC_CSR_BASE 12'hb00
// entry table, one csr per vector
`define CLIC_ENTRY_CSR_BASE 12'hb20
// machine interrupt threshold
`define CLIC_MINTTHRESH_ADDR 12'h347
// read-only nesting depth
`define CLIC_STACK_DEPTH_ADDR 12'h350

`endif
